/* src.f */
+incdir+hdl
hdl/vgaPkg.sv
hdl/vgaRegisterBank.sv
hdl/vgaTimingGenerator.sv
hdl/vgaPixelAddress.sv
hdl/vgaPixelOutput.sv
hdl/vgaController.sv
verif/vgaControllerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the VGA controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module vgaControllerTb -Mdir obj_dir -o simv -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
exit 0

/* verif/vgaControllerTb.sv */
`timescale 1ns/1ps
`include "vga_params.svh"

module vgaControllerTb;
	import vgaPkg::*;

	// Small raster used for the scan tests
	localparam int H_VISIBLE = 19;
	localparam int H_FRONT = 21;
	localparam int H_SYNC = 24;
	localparam int H_WHOLE = 29;
	localparam int V_VISIBLE = 3;
	localparam int V_FRONT = 4;
	localparam int V_SYNC = 5;
	localparam int V_WHOLE = 7;
	localparam int LINE_CYCLES = H_WHOLE + 1;
	localparam int FRAME_CYCLES = LINE_CYCLES * (V_WHOLE + 1);
	localparam int WORDS_PER_ROW = (H_VISIBLE + 1) / 5;
	localparam int SCAN_CYCLES = 4 * FRAME_CYCLES;
	localparam int BUS_OPS = 22;
	localparam int SETUP_CYCLES = 4 + 16 + 9 + 2;
	localparam int CYCLE_LIMIT = 2 * (BUS_OPS + SETUP_CYCLES + SCAN_CYCLES);
	localparam int NUM_TESTS = 6;

	typedef struct packed {
		logic isWrite;
		logic [`VGA_BUS_ADDRESS_BITS-1:0] address;
		logic [3:0] byteSelect;
		logic [31:0] data;
		logic [31:0] expRead;
		logic expRequest;
	} busOp_t;

	logic vga_clk;
	logic rstN;
	busRequest_t bus;
	logic [31:0] vgaData;
	logic [31:0] dataRead;
	logic requestOutput;
	logic [`VGA_ADDRESS_BITS-1:0] vgaAddress;
	logic fetchData;
	pixelColour_t colour;
	logic hsync;
	logic vsync;

	logic [31:0] memory [2**`VGA_ADDRESS_BITS];
	logic [`VGA_ADDRESS_BITS-1:0] lastAddress;
	busOp_t busTable[$];
	int seed;
	int cycleCount;
	int errorCount;
	int currentTest;
	int testErrors[NUM_TESTS];
	string testNames[NUM_TESTS];

	vgaController DUT (
		.vga_clk(vga_clk),
		.rstN(rstN),
		.bus(bus),
		.vgaData(vgaData),
		.dataRead(dataRead),
		.requestOutput(requestOutput),
		.vgaAddress(vgaAddress),
		.fetchData(fetchData),
		.colour(colour),
		.hsync(hsync),
		.vsync(vsync)
	);

	always #5 vga_clk = ~vga_clk;

	always @(posedge vga_clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	// Memory answers one cycle after the fetch
	always @(negedge vga_clk) begin
		vgaData <= memory[lastAddress];
		lastAddress <= vgaAddress;
	end

	task automatic noteError();
		errorCount++;
		testErrors[currentTest]++;
	endtask

	task automatic reportProblem(input string text);
		$display("%s", text);
		noteError();
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error: %s got %h expected %h", name, got, expected);
			noteError();
		end
	endtask

	task automatic checkColour(input string name, input pixelColour_t got,
		input pixelColour_t expected);
		if (got !== expected) begin
			$display("Error: %s got %h expected %h", name, got, expected);
			noteError();
		end
	endtask

	task automatic checkAddress(input string name, input logic [`VGA_ADDRESS_BITS-1:0] got,
		input logic [`VGA_ADDRESS_BITS-1:0] expected);
		if (got !== expected) begin
			$display("Error: %s got %h expected %h", name, got, expected);
			noteError();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("Error: %s got %h expected %h", name, got, expected);
			noteError();
		end
	endtask

	function automatic void addOp(input logic isWrite, input logic [11:0] page,
		input logic [11:0] offset, input logic [3:0] byteSelect, input logic [31:0] data,
		input logic [31:0] expRead, input logic expRequest);
		busTable.push_back(busOp_t'({isWrite, page, offset, byteSelect, data, expRead,
			expRequest}));
	endfunction

	task automatic applyBusOp(input busOp_t op);
		@(negedge vga_clk);
		bus.writeEnable = op.isWrite;
		bus.readEnable = !op.isWrite;
		bus.address = op.address;
		bus.byteSelect = op.byteSelect;
		bus.dataWrite = op.data;
		#1;
		checkWord("dataRead", dataRead, op.expRead);
		checkBit("requestOutput", requestOutput, op.expRequest);
	endtask

	task automatic writeRegister(input logic [11:0] offset, input logic [31:0] data);
		applyBusOp(busOp_t'({1'b1, `VGA_CONFIG_PAGE, offset, 4'hF, data, 32'hFFFF_FFFF, 1'b0}));
	endtask

	task automatic finishTest(input int index);
		$display("Test %0d %s: %s", index + 1, testNames[index],
			(testErrors[index] == 0) ? "passed" : "failed");
	endtask

	// Sub-pixel index is buffered, so the field lags the scan by one cycle
	function automatic pixelColour_t expectedColour(input int h, input int v);
		int k;
		logic [31:0] word;
		if (h > H_VISIBLE || v > V_VISIBLE) begin
			return '0;
		end
		k = (h == 0) ? 0 : h - 1;
		word = memory[(k / 5) * 4];
		return pixelColour_t'(word[(k % 5) * 6 +: 6]);
	endfunction

	function automatic logic [`VGA_ADDRESS_BITS-1:0] rowStartAddress(input logic tight,
		input int row);
		if (tight) begin
			return `VGA_ADDRESS_BITS'(row * WORDS_PER_ROW * 4);
		end
		return `VGA_ADDRESS_BITS'(row << (`VGA_RAW_COLUMN_BITS + 2));
	endfunction

	initial begin
		int t;
		int h;
		int v;
		int frame;
		int lastHFall;
		int lastVFall;
		int hFalls;
		int vFalls;
		int passedTests;
		logic lastH;
		logic lastV;
		logic [`VGA_ADDRESS_BITS-1:0] rowFetches[$];
		vga_clk = 1'b0;
		rstN = 1'b0;
		bus = '0;
		vgaData = '0;
		lastAddress = '0;
		cycleCount = 0;
		errorCount = 0;
		currentTest = 0;
		seed = 32'h886d_0c62;
		for (int i = 0; i < 2**`VGA_ADDRESS_BITS; i++) begin
			memory[i] = $random(seed);
		end
		for (int i = 0; i < NUM_TESTS; i++) begin
			testErrors[i] = 0;
		end
		testNames[0] = "register bank";
		testNames[1] = "disabled output";
		testNames[2] = "hsync timing";
		testNames[3] = "vsync timing";
		testNames[4] = "RAW addressing";
		testNames[5] = "TIGHT addressing";
		repeat (4) @(posedge vga_clk);
		@(negedge vga_clk);
		rstN = 1'b1;

		// Defaults, byte-masked writes, read-only status, unmapped reads
		addOp(0, `VGA_CONFIG_PAGE, REG_CONFIG, 4'hF, 0, 32'h0AA, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_H_VISIBLE, 4'hF, 0, 32'h31F, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_H_FRONT, 4'hF, 0, 32'h347, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_H_SYNC, 4'hF, 0, 32'h3C7, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_H_WHOLE, 4'hF, 0, 32'h41F, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_V_VISIBLE, 4'hF, 0, 32'h257, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_V_FRONT, 4'hF, 0, 32'h258, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_V_SYNC, 4'hF, 0, 32'h25C, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_V_WHOLE, 4'hF, 0, 32'h273, 1);
		addOp(0, `VGA_CONFIG_PAGE, REG_STATUS, 4'hF, 0, 32'h18, 1);
		addOp(1, `VGA_CONFIG_PAGE, REG_H_VISIBLE, 4'h1, 32'hFFFF_FF13, 32'hFFFF_FFFF, 0);
		addOp(0, `VGA_CONFIG_PAGE, REG_H_VISIBLE, 4'hF, 0, 32'h313, 1);
		addOp(1, `VGA_CONFIG_PAGE, REG_V_SYNC, 4'h2, 32'h0000_AB00, 32'hFFFF_FFFF, 0);
		addOp(0, `VGA_CONFIG_PAGE, REG_V_SYNC, 4'hF, 0, 32'h35C, 1);
		addOp(1, `VGA_CONFIG_PAGE, REG_H_FRONT, 4'hF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
		addOp(0, `VGA_CONFIG_PAGE, REG_H_FRONT, 4'hF, 0, 32'h7FF, 1);
		addOp(1, `VGA_CONFIG_PAGE, REG_STATUS, 4'hF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
		addOp(0, `VGA_CONFIG_PAGE, REG_STATUS, 4'hF, 0, 32'h18, 1);
		addOp(0, `VGA_CONFIG_PAGE, 12'h004, 4'hF, 0, 32'hFFFF_FFFF, 0);
		addOp(0, 12'h801, REG_H_VISIBLE, 4'hF, 0, 32'hFFFF_FFFF, 0);
		addOp(1, `VGA_CONFIG_PAGE, REG_CONFIG, 4'h1, 32'h0000_0011, 32'hFFFF_FFFF, 0);
		addOp(0, `VGA_CONFIG_PAGE, REG_CONFIG, 4'hF, 0, 32'h011, 1);
		foreach (busTable[i]) begin
			applyBusOp(busTable[i]);
		end
		finishTest(0);

		currentTest = 1;
		repeat (16) begin
			@(negedge vga_clk);
			bus = '0;
			#1;
			checkBit("hsync", hsync, 1'b1);
			checkBit("vsync", vsync, 1'b1);
			checkBit("fetchData", fetchData, 1'b0);
			checkColour("colour", colour, '0);
		end
		finishTest(1);

		currentTest = 2;
		writeRegister(REG_H_VISIBLE, H_VISIBLE);
		writeRegister(REG_H_FRONT, H_FRONT);
		writeRegister(REG_H_SYNC, H_SYNC);
		writeRegister(REG_H_WHOLE, H_WHOLE);
		writeRegister(REG_V_VISIBLE, V_VISIBLE);
		writeRegister(REG_V_FRONT, V_FRONT);
		writeRegister(REG_V_SYNC, V_SYNC);
		writeRegister(REG_V_WHOLE, V_WHOLE);
		// Enabled, RAW, pixel sizes 1 and 1
		writeRegister(REG_CONFIG, 32'h411);
		@(negedge vga_clk);
		bus = '0;

		// Scan position t counts cycles from the first enabled cycle
		lastH = 1'b1;
		lastV = 1'b1;
		lastHFall = -1;
		lastVFall = -1;
		hFalls = 0;
		vFalls = 0;
		for (t = 0; t < SCAN_CYCLES; t++) begin
			if (t > 0) begin
				@(negedge vga_clk);
			end
			h = t % LINE_CYCLES;
			v = (t / LINE_CYCLES) % (V_WHOLE + 1);
			frame = t / FRAME_CYCLES;

			currentTest = 2;
			if (lastH && !hsync) begin
				if (lastHFall >= 0) begin
					checkWord("hsync period", 32'(t - lastHFall), LINE_CYCLES);
				end
				lastHFall = t;
				hFalls++;
			end else if (!lastH && hsync) begin
				checkWord("hsync low width", 32'(t - lastHFall), H_SYNC - H_FRONT);
			end
			lastH = hsync;

			currentTest = 3;
			if (lastV && !vsync) begin
				if (lastVFall >= 0) begin
					checkWord("vsync period", 32'(t - lastVFall), FRAME_CYCLES);
				end
				lastVFall = t;
				vFalls++;
			end else if (!lastV && vsync) begin
				checkWord("vsync low width", 32'(t - lastVFall),
					(V_SYNC - V_FRONT) * LINE_CYCLES);
			end
			lastV = vsync;

			// From leaving the visible rows until the last word of row 0
			currentTest = 4;
			if (t >= (V_VISIBLE + 1) * LINE_CYCLES && t < FRAME_CYCLES + H_VISIBLE &&
				fetchData) begin
				rowFetches.push_back(vgaAddress);
			end
			if (frame == 1 && (v == 0 || v > V_VISIBLE)) begin
				checkColour("colour", colour, expectedColour(h, v));
			end

			if (h == H_VISIBLE + 1 && v < 2 && (frame == 1 || frame == 3)) begin
				currentTest = (frame == 1) ? 4 : 5;
				checkBit("fetchData", fetchData, 1'b1);
				checkAddress("vgaAddress", vgaAddress, rowStartAddress(frame == 3, v + 1));
			end

			// Switch to TIGHT at the start of frame 2
			if (t == 2 * FRAME_CYCLES) begin
				bus.writeEnable = 1'b1;
				bus.address = {`VGA_CONFIG_PAGE, REG_CONFIG};
				bus.byteSelect = 4'hF;
				bus.dataWrite = 32'h511;
			end else begin
				bus = '0;
			end
		end

		currentTest = 2;
		if (hFalls < SCAN_CYCLES / LINE_CYCLES - 1) begin
			reportProblem($sformatf("Only %0d hsync pulses were seen", hFalls));
		end
		finishTest(2);
		currentTest = 3;
		if (vFalls < 3) begin
			reportProblem($sformatf("Only %0d vsync pulses were seen", vFalls));
		end
		finishTest(3);
		currentTest = 4;
		if (rowFetches.size() != WORDS_PER_ROW) begin
			reportProblem($sformatf("Row 0 had %0d fetches instead of %0d",
				rowFetches.size(), WORDS_PER_ROW));
		end else begin
			foreach (rowFetches[i]) begin
				checkAddress("vgaAddress", rowFetches[i], `VGA_ADDRESS_BITS'(i * 4));
			end
		end
		finishTest(4);
		finishTest(5);

		passedTests = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			if (testErrors[i] == 0) begin
				passedTests++;
			end
		end
		$display("%0d of %0d tests passed, %0d errors", passedTests, NUM_TESTS, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* hdl/vgaController.sv */
`timescale 1ns/1ps
`include "vga_params.svh"

module vgaController (
	input logic vga_clk,
	input logic rstN,
	input vgaPkg::busRequest_t bus,
	input logic [31:0] vgaData,
	output logic [31:0] dataRead,
	output logic requestOutput,
	output logic [`VGA_ADDRESS_BITS-1:0] vgaAddress,
	output logic fetchData,
	output vgaPkg::pixelColour_t colour,
	output logic hsync,
	output logic vsync
);
	import vgaPkg::*;

	displayConfig_t display;
	timingConfig_t timing;
	scanState_t scan;
	logic [2:0] subPixel;

	vgaRegisterBank registerBank (
		.vga_clk(vga_clk),
		.rstN(rstN),
		.bus(bus),
		.scan(scan),
		.syncPins({vsync, hsync}),
		.dataRead(dataRead),
		.requestOutput(requestOutput),
		.display(display),
		.timing(timing)
	);

	vgaTimingGenerator timingGenerator (
		.vga_clk(vga_clk),
		.rstN(rstN),
		.enableOutput(display.enableOutput),
		.timing(timing),
		.scan(scan)
	);

	vgaPixelAddress pixelAddress (
		.vga_clk(vga_clk),
		.rstN(rstN),
		.display(display),
		.scan(scan),
		.vgaAddress(vgaAddress),
		.fetchData(fetchData),
		.subPixel(subPixel)
	);

	vgaPixelOutput pixelOutput (
		.vga_clk(vga_clk),
		.rstN(rstN),
		.enableOutput(display.enableOutput),
		.fetchData(fetchData),
		.vgaData(vgaData),
		.subPixel(subPixel),
		.scan(scan),
		.colour(colour),
		.hsync(hsync),
		.vsync(vsync)
	);

endmodule

/* hdl/vgaPixelOutput.sv */
`timescale 1ns/1ps

module vgaPixelOutput (
	input logic vga_clk,
	input logic rstN,
	input logic enableOutput,
	input logic fetchData,
	input logic [31:0] vgaData,
	input logic [2:0] subPixel,
	input vgaPkg::scanState_t scan,
	output vgaPkg::pixelColour_t colour,
	output logic hsync,
	output logic vsync
);
	import vgaPkg::*;

	logic loadData;
	logic [31:0] pixelWord;
	// Each stage holds {vsync, hsync}
	logic [2:0][1:0] syncDelay;
	logic [5:0] selectedPixel;
	logic onScreen;

	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			loadData <= 1'b0;
			syncDelay <= '1;
		end else if (!enableOutput) begin
			loadData <= 1'b0;
			syncDelay <= '1;
		end else begin
			loadData <= fetchData;
			syncDelay <= {syncDelay[1:0], scan.vsync, scan.hsync};
		end
	end

	// Memory answers the cycle after the fetch
	always_ff @(posedge vga_clk) begin
		if (!enableOutput) begin
			pixelWord <= '0;
		end else if (loadData) begin
			pixelWord <= vgaData;
		end
	end

	always_comb begin
		case (subPixel)
			3'd1: selectedPixel = pixelWord[11:6];
			3'd2: selectedPixel = pixelWord[17:12];
			3'd3: selectedPixel = pixelWord[23:18];
			3'd4: selectedPixel = pixelWord[29:24];
			default: selectedPixel = pixelWord[5:0];
		endcase
	end

	assign onScreen = scan.inHorizontalVisibleArea && scan.inVerticalVisibleArea;
	assign colour = (enableOutput && onScreen) ? pixelColour_t'(selectedPixel) : '0;
	assign hsync = enableOutput ? syncDelay[2][0] : 1'b1;
	assign vsync = enableOutput ? syncDelay[2][1] : 1'b1;

endmodule

/* hdl/vgaPixelAddress.sv */
`timescale 1ns/1ps
`include "vga_params.svh"

module vgaPixelAddress (
	input logic vga_clk,
	input logic rstN,
	input vgaPkg::displayConfig_t display,
	input vgaPkg::scanState_t scan,
	output logic [`VGA_ADDRESS_BITS-1:0] vgaAddress,
	output logic fetchData,
	output logic [2:0] subPixel
);
	import vgaPkg::*;

	logic [3:0] hStretch, hStretchNext, hStretchPlus;
	logic [3:0] vStretch, vStretchNext, vStretchPlus;
	logic [2:0] subCount, subCountNext;
	logic [`VGA_H_BITS-1:0] column, columnNext, columnPlus;
	logic [`VGA_V_BITS-1:0] row, rowNext;
	logic [`VGA_ADDRESS_BITS-3:0] base, baseNext, linearNext;

	assign hStretchPlus = hStretch + 4'd1;
	assign vStretchPlus = vStretch + 4'd1;
	assign columnPlus = column + 1'b1;

	always_comb begin
		hStretchNext = hStretch;
		vStretchNext = vStretch;
		subCountNext = subCount;
		columnNext = column;
		rowNext = row;
		baseNext = base;
		if (!display.enableOutput || !scan.inVerticalVisibleArea) begin
			hStretchNext = '0;
			vStretchNext = '0;
			subCountNext = '0;
			columnNext = '0;
			rowNext = '0;
			baseNext = '0;
		end else begin
			if (!scan.inHorizontalVisibleArea) begin
				hStretchNext = '0;
				subCountNext = '0;
				columnNext = '0;
			end else if (hStretchPlus == display.horizontalPixelSize) begin
				hStretchNext = '0;
				if (subCount == `VGA_MAX_SUB_PIXEL) begin
					subCountNext = '0;
					columnNext = columnPlus;
				end else begin
					subCountNext = subCount + 3'd1;
				end
			end else begin
				hStretchNext = hStretchPlus;
			end

			// Base moves by the number of words in the finished line
			if (scan.endHorizontalVisibleArea) begin
				if (vStretchPlus == display.verticalPixelSize) begin
					vStretchNext = '0;
					rowNext = row + 1'b1;
					baseNext = base + columnPlus[`VGA_ADDRESS_BITS-3:0];
				end else begin
					vStretchNext = vStretchPlus;
				end
			end
		end
	end

	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			hStretch <= '0;
			vStretch <= '0;
			subCount <= '0;
			subPixel <= '0;
			column <= '0;
			row <= '0;
			base <= '0;
		end else begin
			hStretch <= hStretchNext;
			vStretch <= vStretchNext;
			subCount <= subCountNext;
			subPixel <= subCount;
			column <= columnNext;
			row <= rowNext;
			base <= baseNext;
		end
	end

	// Next-state counters put the address out one cycle ahead of the data
	assign linearNext = baseNext + columnNext[`VGA_ADDRESS_BITS-3:0];
	assign fetchData = display.enableOutput && ((rowNext != row) || (columnNext != column));

	always_comb begin
		vgaAddress = '0;
		if (display.enableOutput) begin
			case (display.drawMode)
				DRAW_TIGHT: vgaAddress = {linearNext, 2'b00};
				default: vgaAddress = {rowNext[`VGA_RAW_ROW_BITS-1:0],
					columnNext[`VGA_RAW_COLUMN_BITS-1:0], 2'b00};
			endcase
		end
	end

	subPixelInRange: assert property (@(posedge vga_clk) disable iff (!rstN)
		subPixel <= `VGA_MAX_SUB_PIXEL);

endmodule

/* hdl/vgaTimingGenerator.sv */
`timescale 1ns/1ps
`include "vga_params.svh"

module vgaTimingGenerator (
	input logic vga_clk,
	input logic rstN,
	input logic enableOutput,
	input vgaPkg::timingConfig_t timing,
	output vgaPkg::scanState_t scan
);

	logic [`VGA_H_BITS-1:0] hCounter;
	logic [`VGA_V_BITS-1:0] vCounter;
	logic hVisibleArea;
	logic vVisibleArea;
	logic hsyncRaw;
	logic vsyncRaw;
	logic hEndVisible;
	logic hEndFront;
	logic hEndSync;
	logic hEndWhole;
	logic vEndVisible;
	logic vEndFront;
	logic vEndSync;
	logic vEndWhole;

	assign hEndVisible = hCounter == timing.hVisible;
	assign hEndFront = hCounter == timing.hFrontPorch;
	assign hEndSync = hCounter == timing.hSync;
	assign hEndWhole = hCounter == timing.hWholeLine;
	assign vEndVisible = vCounter == timing.vVisible;
	assign vEndFront = vCounter == timing.vFrontPorch;
	assign vEndSync = vCounter == timing.vSync;
	assign vEndWhole = vCounter == timing.vWholeLine;

	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			hCounter <= '0;
			vCounter <= '0;
			hVisibleArea <= 1'b1;
			vVisibleArea <= 1'b1;
			hsyncRaw <= 1'b1;
			vsyncRaw <= 1'b1;
		end else if (!enableOutput) begin
			hCounter <= '0;
			vCounter <= '0;
			hVisibleArea <= 1'b1;
			vVisibleArea <= 1'b1;
			hsyncRaw <= 1'b1;
			vsyncRaw <= 1'b1;
		end else begin
			hCounter <= hEndWhole ? '0 : hCounter + 1'b1;
			if (hEndVisible) begin
				hVisibleArea <= 1'b0;
			end else if (hEndWhole) begin
				hVisibleArea <= 1'b1;
			end
			if (hEndFront) begin
				hsyncRaw <= 1'b0;
			end else if (hEndSync) begin
				hsyncRaw <= 1'b1;
			end

			// Vertical side only moves once per line
			if (hEndWhole) begin
				vCounter <= vEndWhole ? '0 : vCounter + 1'b1;
				if (vEndVisible) begin
					vVisibleArea <= 1'b0;
				end else if (vEndWhole) begin
					vVisibleArea <= 1'b1;
				end
				if (vEndFront) begin
					vsyncRaw <= 1'b0;
				end else if (vEndSync) begin
					vsyncRaw <= 1'b1;
				end
			end
		end
	end

	assign scan.inHorizontalVisibleArea = hVisibleArea;
	assign scan.inVerticalVisibleArea = vVisibleArea;
	assign scan.endHorizontalVisibleArea = hEndVisible;
	assign scan.endHorizontalWholeLine = hEndWhole;
	assign scan.hsync = hsyncRaw;
	assign scan.vsync = vsyncRaw;

	hCounterInRange: assert property (@(posedge vga_clk) disable iff (!rstN || !enableOutput)
		hCounter <= timing.hWholeLine);

endmodule

/* hdl/vgaRegisterBank.sv */
`timescale 1ns/1ps
`include "vga_params.svh"

module vgaRegisterBank (
	input logic vga_clk,
	input logic rstN,
	input vgaPkg::busRequest_t bus,
	input vgaPkg::scanState_t scan,
	input logic [1:0] syncPins,
	output logic [31:0] dataRead,
	output logic requestOutput,
	output vgaPkg::displayConfig_t display,
	output vgaPkg::timingConfig_t timing
);
	import vgaPkg::*;

	logic pageSelect;
	registerOffset_t offset;
	logic [9:0] readHit;
	logic [31:0] statusWord;
	logic [31:0] selectedValue;
	logic [31:0] mergedWrite;

	assign pageSelect = bus.address[`VGA_BUS_ADDRESS_BITS-1 -: 12] == `VGA_CONFIG_PAGE;
	assign offset = registerOffset_t'(bus.address[11:0]);

	assign readHit = {
		offset == REG_STATUS,
		offset == REG_V_WHOLE,
		offset == REG_V_SYNC,
		offset == REG_V_FRONT,
		offset == REG_V_VISIBLE,
		offset == REG_H_WHOLE,
		offset == REG_H_SYNC,
		offset == REG_H_FRONT,
		offset == REG_H_VISIBLE,
		offset == REG_CONFIG
	} & {10{pageSelect}};

	// syncPins is {vsync, hsync}; the pins are active low
	assign statusWord = {27'b0, scan.inVerticalVisibleArea, scan.inHorizontalVisibleArea,
		!syncPins[1], !syncPins[0], display.enableOutput};

	always_comb begin
		selectedValue = '1;
		case (offset)
			REG_CONFIG: selectedValue = 32'(display);
			REG_H_VISIBLE: selectedValue = 32'(timing.hVisible);
			REG_H_FRONT: selectedValue = 32'(timing.hFrontPorch);
			REG_H_SYNC: selectedValue = 32'(timing.hSync);
			REG_H_WHOLE: selectedValue = 32'(timing.hWholeLine);
			REG_V_VISIBLE: selectedValue = 32'(timing.vVisible);
			REG_V_FRONT: selectedValue = 32'(timing.vFrontPorch);
			REG_V_SYNC: selectedValue = 32'(timing.vSync);
			REG_V_WHOLE: selectedValue = 32'(timing.vWholeLine);
			REG_STATUS: selectedValue = statusWord;
			default: selectedValue = '1;
		endcase
	end

	assign requestOutput = bus.readEnable && (|readHit);
	assign dataRead = requestOutput ? selectedValue : '1;

	// Unselected bytes keep the current register contents
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			mergedWrite[i*8 +: 8] = bus.byteSelect[i] ? bus.dataWrite[i*8 +: 8]
				: selectedValue[i*8 +: 8];
		end
	end

	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			display <= displayConfig_t'(`VGA_DEFAULT_CONFIG);
			timing.hVisible <= `VGA_DEFAULT_H_VISIBLE;
			timing.hFrontPorch <= `VGA_DEFAULT_H_FRONT;
			timing.hSync <= `VGA_DEFAULT_H_SYNC;
			timing.hWholeLine <= `VGA_DEFAULT_H_WHOLE;
			timing.vVisible <= `VGA_DEFAULT_V_VISIBLE;
			timing.vFrontPorch <= `VGA_DEFAULT_V_FRONT;
			timing.vSync <= `VGA_DEFAULT_V_SYNC;
			timing.vWholeLine <= `VGA_DEFAULT_V_WHOLE;
		end else if (bus.writeEnable && pageSelect) begin
			case (offset)
				REG_CONFIG: display <= displayConfig_t'(mergedWrite[$bits(displayConfig_t)-1:0]);
				REG_H_VISIBLE: timing.hVisible <= mergedWrite[`VGA_H_BITS-1:0];
				REG_H_FRONT: timing.hFrontPorch <= mergedWrite[`VGA_H_BITS-1:0];
				REG_H_SYNC: timing.hSync <= mergedWrite[`VGA_H_BITS-1:0];
				REG_H_WHOLE: timing.hWholeLine <= mergedWrite[`VGA_H_BITS-1:0];
				REG_V_VISIBLE: timing.vVisible <= mergedWrite[`VGA_V_BITS-1:0];
				REG_V_FRONT: timing.vFrontPorch <= mergedWrite[`VGA_V_BITS-1:0];
				REG_V_SYNC: timing.vSync <= mergedWrite[`VGA_V_BITS-1:0];
				REG_V_WHOLE: timing.vWholeLine <= mergedWrite[`VGA_V_BITS-1:0];
				// Status and unmapped offsets are read only
				default: ;
			endcase
		end
	end

	// Registers change only on a write that hits a writable register
	writeOnlyOnHit: assert property (@(posedge vga_clk) disable iff (!rstN)
		!(bus.writeEnable && (|readHit[8:0])) |=> $stable(display) && $stable(timing));

endmodule

/* hdl/vgaPkg.sv */
`include "vga_params.svh"

package vgaPkg;

	// Codes 2 and 3 fall back to RAW addressing
	typedef enum logic [1:0] {
		DRAW_RAW = 2'd0,
		DRAW_TIGHT = 2'd1
	} drawMode_t;

	typedef enum logic [11:0] {
		REG_CONFIG = 12'h000,
		REG_H_VISIBLE = 12'h010,
		REG_H_FRONT = 12'h014,
		REG_H_SYNC = 12'h018,
		REG_H_WHOLE = 12'h01C,
		REG_V_VISIBLE = 12'h020,
		REG_V_FRONT = 12'h024,
		REG_V_SYNC = 12'h028,
		REG_V_WHOLE = 12'h02C,
		REG_STATUS = 12'h030
	} registerOffset_t;

	typedef struct packed {
		logic writeEnable;
		logic readEnable;
		logic [`VGA_BUS_ADDRESS_BITS-1:0] address;
		logic [3:0] byteSelect;
		logic [31:0] dataWrite;
	} busRequest_t;

	// Declared high to low, so horizontalPixelSize sits in bits 3:0
	typedef struct packed {
		logic enableOutput;
		drawMode_t drawMode;
		logic [3:0] verticalPixelSize;
		logic [3:0] horizontalPixelSize;
	} displayConfig_t;

	typedef struct packed {
		logic [`VGA_H_BITS-1:0] hVisible;
		logic [`VGA_H_BITS-1:0] hFrontPorch;
		logic [`VGA_H_BITS-1:0] hSync;
		logic [`VGA_H_BITS-1:0] hWholeLine;
		logic [`VGA_V_BITS-1:0] vVisible;
		logic [`VGA_V_BITS-1:0] vFrontPorch;
		logic [`VGA_V_BITS-1:0] vSync;
		logic [`VGA_V_BITS-1:0] vWholeLine;
	} timingConfig_t;

	typedef struct packed {
		logic inHorizontalVisibleArea;
		logic inVerticalVisibleArea;
		logic endHorizontalVisibleArea;
		logic endHorizontalWholeLine;
		logic hsync;
		logic vsync;
	} scanState_t;

	typedef struct packed {
		logic [1:0] blue;
		logic [1:0] green;
		logic [1:0] red;
	} pixelColour_t;

endpackage

/* hdl/vga_params.svh */
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// Memory word address and bus widths
`define VGA_ADDRESS_BITS 13
`define VGA_BUS_ADDRESS_BITS 24
`define VGA_CONFIG_PAGE 12'h800

// Scan counter widths
`define VGA_H_BITS 11
`define VGA_V_BITS 10

// Five 6-bit sub-pixels per 32-bit word
`define VGA_MAX_SUB_PIXEL 3'd4
`define VGA_RAW_ROW_BITS 7
`define VGA_RAW_COLUMN_BITS 4

// Register reset values, 800x600 at 60 Hz
`define VGA_DEFAULT_CONFIG 11'h0AA
`define VGA_DEFAULT_H_VISIBLE 11'd799
`define VGA_DEFAULT_H_FRONT 11'd839
`define VGA_DEFAULT_H_SYNC 11'd967
`define VGA_DEFAULT_H_WHOLE 11'd1055
`define VGA_DEFAULT_V_VISIBLE 10'd599
`define VGA_DEFAULT_V_FRONT 10'd600
`define VGA_DEFAULT_V_SYNC 10'd604
`define VGA_DEFAULT_V_WHOLE 10'd627

`endif
